/* verilog.f */
hdl/cache_pkg.sv
hdl/bank_op_if.sv
hdl/sync_fifo.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/bank_pipeline.sv
hdl/cache_bank.sv
verif/tb_clock.sv
verif/cache_bank_sva.sv
verif/cache_bank_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cache_bank_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/cache_bank_tb.sv */
// random traffic over line addresses 0 to 31 only; the memory model serves one line read at a time
`timescale 1ns/1ns

module cache_bank_tb;

    localparam int NUM_REQS    = 400;
    localparam int CYCLE_LIMIT = NUM_REQS * 40;
    localparam int MEM_LINES   = 32;
    localparam int WORD_W      = $bits(cache_pkg::word_t);

    typedef struct packed {
        logic                  rw;
        cache_pkg::line_addr_t addr;
        cache_pkg::word_sel_t  wsel;
        cache_pkg::byteen_t    byteen;
        cache_pkg::word_t      data;
    } mem_req_t;

    logic                  clk;
    logic                  reset;
    logic                  core_req_valid;
    cache_pkg::line_addr_t core_req_addr;
    logic                  core_req_rw;
    cache_pkg::word_sel_t  core_req_wsel;
    cache_pkg::byteen_t    core_req_byteen;
    cache_pkg::word_t      core_req_data;
    cache_pkg::req_tag_t   core_req_tag;
    logic                  core_req_ready;
    logic                  core_rsp_valid;
    cache_pkg::word_t      core_rsp_data;
    cache_pkg::req_tag_t   core_rsp_tag;
    logic                  core_rsp_ready;
    logic                  mem_req_valid;
    cache_pkg::line_addr_t mem_req_addr;
    logic                  mem_req_rw;
    cache_pkg::word_sel_t  mem_req_wsel;
    cache_pkg::byteen_t    mem_req_byteen;
    cache_pkg::word_t      mem_req_data;
    logic                  mem_req_ready;
    logic                  mem_rsp_valid;
    cache_pkg::line_t      mem_rsp_data;
    logic                  mem_rsp_ready;

    // memory contents, and the same memory as the core sees it at acceptance
    cache_pkg::line_t     mem_lines [MEM_LINES];
    cache_pkg::word_t     shadow [MEM_LINES][cache_pkg::WORDS_PER_LINE];
    logic                 model_valid [cache_pkg::NUM_LINES];
    cache_pkg::line_tag_t model_tag [cache_pkg::NUM_LINES];

    cache_pkg::word_t    exp_rsp_data [$];
    cache_pkg::req_tag_t exp_rsp_tag [$];
    mem_req_t            exp_mreq [$];

    integer                seed;
    int                    sent;
    int                    cycles;
    logic                  rd_pending;
    cache_pkg::line_addr_t rd_addr;
    int                    rd_delay;

    tb_clock i_tb_clock (
        .clk (clk)
    );

    cache_bank i_cache_bank (
        .clk             (clk),
        .reset           (reset),
        .core_req_valid  (core_req_valid),
        .core_req_addr   (core_req_addr),
        .core_req_rw     (core_req_rw),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_data   (core_rsp_data),
        .core_rsp_tag    (core_rsp_tag),
        .core_rsp_ready  (core_rsp_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req_addr    (mem_req_addr),
        .mem_req_rw      (mem_req_rw),
        .mem_req_wsel    (mem_req_wsel),
        .mem_req_byteen  (mem_req_byteen),
        .mem_req_data    (mem_req_data),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .mem_rsp_ready   (mem_rsp_ready)
    );

    // odd multiplier keeps every word of every line distinct
    function automatic cache_pkg::word_t initial_word(input int line, input int word);
        return cache_pkg::word_t'((line * 4 + word + 1) * 32'h9E37_79B9);
    endfunction

    function automatic cache_pkg::word_t merge_word(input cache_pkg::word_t old_word,
                                                    input cache_pkg::word_t new_word,
                                                    input cache_pkg::byteen_t byteen);
        cache_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < cache_pkg::WORD_BYTES; b++) begin
            if (byteen[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            end_with_failure();
        end
    endtask

    task automatic accept_request();
        int                     line;
        cache_pkg::line_index_t index;
        cache_pkg::line_tag_t   tag;
        mem_req_t               req;
        line  = int'(core_req_addr) % MEM_LINES;
        index = core_req_addr[cache_pkg::INDEX_BITS-1:0];
        tag   = core_req_addr[cache_pkg::LINE_ADDR_BITS-1:cache_pkg::INDEX_BITS];
        req   = {core_req_rw, core_req_addr, core_req_wsel, core_req_byteen, core_req_data};
        if (core_req_rw) begin
            shadow[line][core_req_wsel] = merge_word(shadow[line][core_req_wsel],
                                                     core_req_data, core_req_byteen);
            exp_mreq.push_back(req);
        end else begin
            exp_rsp_data.push_back(shadow[line][core_req_wsel]);
            exp_rsp_tag.push_back(core_req_tag);
            // only reads allocate, so only reads can miss into a fill
            if (!(model_valid[index] && model_tag[index] == tag)) begin
                exp_mreq.push_back(req);
                model_valid[index] = 1'b1;
                model_tag[index]   = tag;
            end
        end
    endtask

    task automatic check_response();
        if (exp_rsp_tag.size() == 0) begin
            $display("core response arrived with no read outstanding");
            end_with_failure();
        end else begin
            check_equal(core_rsp_tag, exp_rsp_tag.pop_front(), "response tag");
            check_equal(core_rsp_data, exp_rsp_data.pop_front(), "response data");
        end
    endtask

    task automatic serve_mem_request();
        mem_req_t         exp;
        int               line;
        cache_pkg::word_t old_word;
        if (exp_mreq.size() == 0) begin
            $display("memory request arrived while none was expected");
            end_with_failure();
        end else begin
            exp  = exp_mreq.pop_front();
            line = int'(mem_req_addr) % MEM_LINES;
            check_equal(mem_req_rw, exp.rw, "memory request rw");
            check_equal(mem_req_addr, exp.addr, "memory request address");
            if (mem_req_rw) begin
                check_equal(mem_req_wsel, exp.wsel, "memory write wsel");
                check_equal(mem_req_byteen, exp.byteen, "memory write byteen");
                check_equal(mem_req_data, exp.data, "memory write data");
                old_word = mem_lines[line][int'(mem_req_wsel)*WORD_W +: WORD_W];
                mem_lines[line][int'(mem_req_wsel)*WORD_W +: WORD_W] =
                    merge_word(old_word, mem_req_data, mem_req_byteen);
            end else if (rd_pending) begin
                $display("second line read issued while a fill is still outstanding");
                end_with_failure();
            end else begin
                rd_pending = 1'b1;
                rd_addr    = mem_req_addr;
                rd_delay   = 1 + int'($unsigned($random(seed)) % 6);
            end
        end
    endtask

    task automatic drive_request();
        core_req_valid  = 1'b1;
        core_req_addr   = cache_pkg::line_addr_t'($unsigned($random(seed)) % MEM_LINES);
        core_req_rw     = ($unsigned($random(seed)) % 100) >= 60;
        core_req_wsel   = cache_pkg::word_sel_t'($unsigned($random(seed)) % 4);
        core_req_byteen = cache_pkg::byteen_t'($random(seed));
        core_req_data   = cache_pkg::word_t'($random(seed));
        core_req_tag    = cache_pkg::req_tag_t'(sent);
        sent++;
    endtask

    initial begin
        logic req_fire;
        logic rsp_fire;
        logic mreq_fire;
        logic mrsp_fire;
        int   quiet;
        seed            = 70;
        sent            = 0;
        cycles          = 0;
        quiet           = 0;
        req_fire        = 1'b0;
        rsp_fire        = 1'b0;
        mreq_fire       = 1'b0;
        mrsp_fire       = 1'b0;
        rd_pending      = 1'b0;
        rd_addr         = '0;
        rd_delay        = 0;
        reset           = 1'b1;
        core_req_valid  = 1'b0;
        core_req_addr   = '0;
        core_req_rw     = 1'b0;
        core_req_wsel   = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        core_rsp_ready  = 1'b0;
        mem_req_ready   = 1'b0;
        mem_rsp_valid   = 1'b0;
        mem_rsp_data    = '0;
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
                shadow[l][w] = initial_word(l, w);
                mem_lines[l][w*WORD_W +: WORD_W] = initial_word(l, w);
            end
        end
        for (int i = 0; i < cache_pkg::NUM_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // run until all traffic has drained and the ports stay quiet for a while
        while (quiet < 20) begin
            @(negedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout: traffic did not drain within %0d cycles", CYCLE_LIMIT);
                end_with_failure();
            end

            core_rsp_ready = ($unsigned($random(seed)) % 4) != 0;
            mem_req_ready  = ($unsigned($random(seed)) % 4) != 0;
            if (req_fire || !core_req_valid) begin
                if (sent < NUM_REQS) begin
                    drive_request();
                end else begin
                    core_req_valid = 1'b0;
                end
            end
            if (mrsp_fire) begin
                mem_rsp_valid = 1'b0;
                rd_pending    = 1'b0;
            end else if (rd_pending && !mem_rsp_valid) begin
                rd_delay--;
                if (rd_delay == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = mem_lines[int'(rd_addr) % MEM_LINES];
                end
            end

            // bank outputs come from registers and hold until the next rising edge
            req_fire  = core_req_valid && core_req_ready;
            rsp_fire  = core_rsp_valid && core_rsp_ready;
            mreq_fire = mem_req_valid && mem_req_ready;
            mrsp_fire = mem_rsp_valid && mem_rsp_ready;
            if (req_fire) begin
                accept_request();
            end
            if (rsp_fire) begin
                check_response();
            end
            if (mreq_fire) begin
                serve_mem_request();
            end

            if (sent == NUM_REQS && !core_req_valid && exp_rsp_tag.size() == 0
                    && exp_mreq.size() == 0 && !rd_pending) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verif/cache_bank_sva.sv */
// watches only the outside handshakes of the bank; nothing inside the design is probed
`timescale 1ns/1ns

module cache_bank_sva (
    input logic                  clk,
    input logic                  reset,
    input logic                  core_rsp_valid,
    input logic                  core_rsp_ready,
    input cache_pkg::word_t      core_rsp_data,
    input cache_pkg::req_tag_t   core_rsp_tag,
    input logic                  mem_req_valid,
    input logic                  mem_req_ready,
    input logic                  mem_req_rw,
    input cache_pkg::line_addr_t mem_req_addr,
    input cache_pkg::word_sel_t  mem_req_wsel,
    input cache_pkg::byteen_t    mem_req_byteen,
    input cache_pkg::word_t      mem_req_data,
    input logic                  mem_rsp_ready
);

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !core_rsp_valid && !mem_req_valid && !mem_rsp_ready)
        else $error("a valid or ready output is high right after reset");

    // a response waiting for the core keeps its payload
    rsp_held: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid && !core_rsp_ready |=>
            core_rsp_valid && $stable({core_rsp_data, core_rsp_tag}))
        else $error("core response dropped or changed before it was taken");

    mreq_held: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid
            && $stable({mem_req_rw, mem_req_addr, mem_req_wsel, mem_req_byteen, mem_req_data}))
        else $error("memory request dropped or changed before it was taken");

endmodule

bind cache_bank cache_bank_sva i_cache_bank_sva (
    .clk            (clk),
    .reset          (reset),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp_ready (core_rsp_ready),
    .core_rsp_data  (core_rsp_data),
    .core_rsp_tag   (core_rsp_tag),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_rw     (mem_req_rw),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wsel   (mem_req_wsel),
    .mem_req_byteen (mem_req_byteen),
    .mem_req_data   (mem_req_data),
    .mem_rsp_ready  (mem_rsp_ready)
);

/* verif/tb_clock.sv */
// free-running clock with an 8 ns period, starting low at time zero
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

/* hdl/cache_bank.sv */
// write-through, no write allocate, blocking on a read miss; only one line read is outstanding
`timescale 1ns/1ns

module cache_bank (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  core_req_valid,
    input  cache_pkg::line_addr_t core_req_addr,
    input  logic                  core_req_rw,
    input  cache_pkg::word_sel_t  core_req_wsel,
    input  cache_pkg::byteen_t    core_req_byteen,
    input  cache_pkg::word_t      core_req_data,
    input  cache_pkg::req_tag_t   core_req_tag,
    output logic                  core_req_ready,
    output logic                  core_rsp_valid,
    output cache_pkg::word_t      core_rsp_data,
    output cache_pkg::req_tag_t   core_rsp_tag,
    input  logic                  core_rsp_ready,
    output logic                  mem_req_valid,
    output cache_pkg::line_addr_t mem_req_addr,
    output logic                  mem_req_rw,
    output cache_pkg::word_sel_t  mem_req_wsel,
    output cache_pkg::byteen_t    mem_req_byteen,
    output cache_pkg::word_t      mem_req_data,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  cache_pkg::line_t      mem_rsp_data,
    output logic                  mem_rsp_ready
);

    localparam int RSP_W  = $bits(cache_pkg::word_t) + $bits(cache_pkg::req_tag_t);
    localparam int MREQ_W = 1 + $bits(cache_pkg::line_addr_t) + $bits(cache_pkg::word_sel_t)
                          + $bits(cache_pkg::byteen_t) + $bits(cache_pkg::word_t);

    bank_op_if op ();

    cache_pkg::line_addr_t lookup_addr, fill_addr;
    logic                  hit, fill;

    logic                  rsp_push, rsp_pop, rsp_full, rsp_empty;
    cache_pkg::word_t      rsp_data;
    cache_pkg::req_tag_t   rsp_tag;

    logic                  mreq_push, mreq_pop, mreq_full, mreq_empty;
    logic                  mreq_rw;
    cache_pkg::line_addr_t mreq_addr;
    cache_pkg::word_sel_t  mreq_wsel;
    cache_pkg::byteen_t    mreq_byteen;
    cache_pkg::word_t      mreq_data;

    bank_pipeline i_pipeline (
        .clk             (clk),
        .reset           (reset),
        .core_req_valid  (core_req_valid),
        .core_req_addr   (core_req_addr),
        .core_req_rw     (core_req_rw),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .mem_rsp_ready   (mem_rsp_ready),
        .lookup_addr     (lookup_addr),
        .hit             (hit),
        .fill            (fill),
        .fill_addr       (fill_addr),
        .rsp_full        (rsp_full),
        .rsp_push        (rsp_push),
        .rsp_data        (rsp_data),
        .rsp_tag         (rsp_tag),
        .mreq_full       (mreq_full),
        .mreq_push       (mreq_push),
        .mreq_rw         (mreq_rw),
        .mreq_addr       (mreq_addr),
        .mreq_wsel       (mreq_wsel),
        .mreq_byteen     (mreq_byteen),
        .mreq_data       (mreq_data),
        .op              (op.pipe)
    );

    tag_store i_tag_store (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .fill        (fill),
        .fill_addr   (fill_addr),
        .hit         (hit)
    );

    data_store i_data_store (
        .clk (clk),
        .op  (op.store)
    );

    assign core_rsp_valid = !rsp_empty;
    assign rsp_pop        = core_rsp_valid && core_rsp_ready;

    sync_fifo #(
        .WIDTH (RSP_W),
        .DEPTH (cache_pkg::QUEUE_DEPTH)
    ) i_rsp_queue (
        .clk   (clk),
        .reset (reset),
        .push  (rsp_push),
        .pop   (rsp_pop),
        .din   ({rsp_data, rsp_tag}),
        .dout  ({core_rsp_data, core_rsp_tag}),
        .full  (rsp_full),
        .empty (rsp_empty)
    );

    assign mem_req_valid = !mreq_empty;
    assign mreq_pop      = mem_req_valid && mem_req_ready;

    sync_fifo #(
        .WIDTH (MREQ_W),
        .DEPTH (cache_pkg::QUEUE_DEPTH)
    ) i_mreq_queue (
        .clk   (clk),
        .reset (reset),
        .push  (mreq_push),
        .pop   (mreq_pop),
        .din   ({mreq_rw, mreq_addr, mreq_wsel, mreq_byteen, mreq_data}),
        .dout  ({mem_req_rw, mem_req_addr, mem_req_wsel, mem_req_byteen, mem_req_data}),
        .full  (mreq_full),
        .empty (mreq_empty)
    );

endmodule

/* hdl/bank_pipeline.sv */
// one outstanding miss; the stage-1 read miss is retired on the fill and stage 0 looks up again
`timescale 1ns/1ns

module bank_pipeline (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  core_req_valid,
    input  cache_pkg::line_addr_t core_req_addr,
    input  logic                  core_req_rw,
    input  cache_pkg::word_sel_t  core_req_wsel,
    input  cache_pkg::byteen_t    core_req_byteen,
    input  cache_pkg::word_t      core_req_data,
    input  cache_pkg::req_tag_t   core_req_tag,
    output logic                  core_req_ready,
    input  logic                  mem_rsp_valid,
    input  cache_pkg::line_t      mem_rsp_data,
    output logic                  mem_rsp_ready,
    output cache_pkg::line_addr_t lookup_addr,
    input  logic                  hit,
    output logic                  fill,
    output cache_pkg::line_addr_t fill_addr,
    input  logic                  rsp_full,
    output logic                  rsp_push,
    output cache_pkg::word_t      rsp_data,
    output cache_pkg::req_tag_t   rsp_tag,
    input  logic                  mreq_full,
    output logic                  mreq_push,
    output logic                  mreq_rw,
    output cache_pkg::line_addr_t mreq_addr,
    output cache_pkg::word_sel_t  mreq_wsel,
    output cache_pkg::byteen_t    mreq_byteen,
    output cache_pkg::word_t      mreq_data,
    bank_op_if.pipe               op
);

    localparam int WORD_W = $bits(cache_pkg::word_t);

    logic                  s0_valid, s1_valid;
    cache_pkg::line_addr_t s0_addr, s1_addr;
    logic                  s0_rw, s1_rw;
    cache_pkg::word_sel_t  s0_wsel, s1_wsel;
    cache_pkg::byteen_t    s0_byteen, s1_byteen;
    cache_pkg::word_t      s0_data, s1_data;
    cache_pkg::req_tag_t   s0_tag, s1_tag;
    logic                  s1_hit;

    cache_pkg::pipe_state_t state;

    logic read_hit, read_miss, write_req;
    logic write_go, miss_issue, fill_fire, stall;

    assign read_hit  = s1_valid && !s1_rw && s1_hit;
    assign read_miss = s1_valid && !s1_rw && !s1_hit;
    assign write_req = s1_valid && s1_rw;

    assign write_go   = write_req && !mreq_full;
    assign miss_issue = read_miss && (state != cache_pkg::MISS_WAIT) && !mreq_full;
    assign fill_fire  = mem_rsp_valid && mem_rsp_ready;

    // read miss holds until the fill clears stage 1
    assign stall = (read_hit && rsp_full) || (write_req && mreq_full) || read_miss;

    assign core_req_ready = !stall;
    assign mem_rsp_ready  = (state == cache_pkg::MISS_WAIT) && !rsp_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            s0_valid <= 1'b0;
            s1_valid <= 1'b0;
        end else if (!stall) begin
            s0_valid <= core_req_valid;
            s1_valid <= s0_valid;
        end else if (fill_fire) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s0_addr   <= core_req_addr;
            s0_rw     <= core_req_rw;
            s0_wsel   <= core_req_wsel;
            s0_byteen <= core_req_byteen;
            s0_data   <= core_req_data;
            s0_tag    <= core_req_tag;
            s1_addr   <= s0_addr;
            s1_rw     <= s0_rw;
            s1_wsel   <= s0_wsel;
            s1_byteen <= s0_byteen;
            s1_data   <= s0_data;
            s1_tag    <= s0_tag;
            s1_hit    <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::RUN;
        end else begin
            case (state)
                cache_pkg::RUN, cache_pkg::MISS_ISSUE: begin
                    if (read_miss) begin
                        state <= miss_issue ? cache_pkg::MISS_WAIT : cache_pkg::MISS_ISSUE;
                    end
                end
                cache_pkg::MISS_WAIT: begin
                    if (fill_fire) begin
                        state <= cache_pkg::RUN;
                    end
                end
                default: state <= cache_pkg::RUN;
            endcase
        end
    end

    assign lookup_addr = s0_addr;
    assign fill        = fill_fire;
    assign fill_addr   = s1_addr;

    // data store access
    assign op.op_read   = read_hit;
    assign op.op_write  = write_go && s1_hit;
    assign op.op_fill   = fill_fire;
    assign op.index     = s1_addr[cache_pkg::INDEX_BITS-1:0];
    assign op.wsel      = s1_wsel;
    assign op.byteen    = s1_byteen;
    assign op.wdata     = s1_data;
    assign op.fill_line = mem_rsp_data;

    // missed read is answered straight from the fill line
    assign rsp_push = (read_hit && !rsp_full) || fill_fire;
    assign rsp_data = fill_fire ? mem_rsp_data[s1_wsel*WORD_W +: WORD_W] : op.rdata;
    assign rsp_tag  = s1_tag;

    // line read goes out with rw low
    assign mreq_push   = write_go || miss_issue;
    assign mreq_rw     = s1_rw;
    assign mreq_addr   = s1_addr;
    assign mreq_wsel   = s1_wsel;
    assign mreq_byteen = s1_byteen;
    assign mreq_data   = s1_data;

endmodule

/* hdl/data_store.sv */
// single port used by stage 1 only; contents are undefined until a line is filled
`timescale 1ns/1ns

module data_store (
    input logic       clk,
    bank_op_if.store  op
);

    localparam int WORD_W = $bits(cache_pkg::word_t);

    cache_pkg::line_t lines [cache_pkg::NUM_LINES];
    cache_pkg::line_t cur_line;

    assign cur_line = lines[op.index];

    always_ff @(posedge clk) begin
        if (op.op_fill) begin
            lines[op.index] <= op.fill_line;
        end else if (op.op_write) begin
            // merge only the enabled bytes of the selected word
            for (int b = 0; b < cache_pkg::WORD_BYTES; b++) begin
                if (op.byteen[b]) begin
                    lines[op.index][op.wsel*WORD_W + b*8 +: 8] <= op.wdata[b*8 +: 8];
                end
            end
        end
    end

    assign op.rdata = op.op_read ? cur_line[op.wsel*WORD_W +: WORD_W] : '0;

endmodule

/* hdl/tag_store.sv */
// direct mapped, one tag per line; a fill always overwrites the indexed entry
`timescale 1ns/1ns

module tag_store (
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::line_addr_t lookup_addr,
    input  logic                  fill,
    input  cache_pkg::line_addr_t fill_addr,
    output logic                  hit
);

    logic [cache_pkg::NUM_LINES-1:0] valid;
    cache_pkg::line_tag_t            tags [cache_pkg::NUM_LINES];

    cache_pkg::line_index_t lookup_index;
    cache_pkg::line_tag_t   lookup_tag;
    cache_pkg::line_index_t fill_index;
    cache_pkg::line_tag_t   fill_tag;

    // address split is tag above index
    assign lookup_index = lookup_addr[cache_pkg::INDEX_BITS-1:0];
    assign lookup_tag   = lookup_addr[cache_pkg::LINE_ADDR_BITS-1:cache_pkg::INDEX_BITS];
    assign fill_index   = fill_addr[cache_pkg::INDEX_BITS-1:0];
    assign fill_tag     = fill_addr[cache_pkg::LINE_ADDR_BITS-1:cache_pkg::INDEX_BITS];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (fill) begin
            valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[fill_index] <= fill_tag;
        end
    end

    assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);

endmodule

/* hdl/sync_fifo.sv */
// DEPTH must be a power of two; push when full or pop when empty is not guarded; entries show one cycle after push
`timescale 1ns/1ns

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    logic [WIDTH-1:0]             mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;
    // entries visible on the read side
    logic [$clog2(DEPTH+1)-1:0]   vis_count;
    logic                         push_q;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            vis_count <= '0;
            push_q    <= 1'b0;
        end else begin
            push_q <= push;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({push_q, pop})
                2'b10:   vis_count <= vis_count + 1'b1;
                2'b01:   vis_count <= vis_count - 1'b1;
                default: vis_count <= vis_count;
            endcase
        end
    end

    assign dout  = mem[rd_ptr];
    assign full  = (count == DEPTH);
    assign empty = (vis_count == '0);

endmodule

/* hdl/bank_op_if.sv */
// stage-1 access to the data store; rdata is combinational and only meaningful while op_read is high
`timescale 1ns/1ns

interface bank_op_if;

    logic                   op_read;
    logic                   op_write;
    logic                   op_fill;
    cache_pkg::line_index_t index;
    cache_pkg::word_sel_t   wsel;
    cache_pkg::byteen_t     byteen;
    cache_pkg::word_t       wdata;
    cache_pkg::line_t       fill_line;
    cache_pkg::word_t       rdata;

    modport pipe (
        output op_read, op_write, op_fill, index, wsel, byteen, wdata, fill_line,
        input  rdata
    );

    modport store (
        input  op_read, op_write, op_fill, index, wsel, byteen, wdata, fill_line,
        output rdata
    );

endinterface

/* hdl/cache_pkg.sv */
// sizes are fixed here; NUM_LINES must equal 2**INDEX_BITS and the address split is tag:index
package cache_pkg;

    localparam int WORD_BYTES     = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_LINES      = 16;
    localparam int LINE_ADDR_BITS = 12;
    localparam int INDEX_BITS     = 4;
    localparam int LINE_TAG_BITS  = LINE_ADDR_BITS - INDEX_BITS;
    localparam int REQ_TAG_BITS   = 4;
    localparam int QUEUE_DEPTH    = 4;

    // address fields
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [INDEX_BITS-1:0]     line_index_t;
    typedef logic [LINE_TAG_BITS-1:0]  line_tag_t;

    // payload
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]       word_sel_t;
    typedef logic [WORD_BYTES-1:0]                   byteen_t;
    typedef logic [WORD_BYTES*8-1:0]                 word_t;
    typedef logic [WORDS_PER_LINE*WORD_BYTES*8-1:0]  line_t;
    typedef logic [REQ_TAG_BITS-1:0]                 req_tag_t;

    // miss sequencing of the pipeline
    typedef enum logic [1:0] {
        RUN,
        MISS_ISSUE,
        MISS_WAIT
    } pipe_state_t;

endpackage
